// ==== Makefile ====
TOP := tb_control_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f all.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+include
hdl/cpu_ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/step_counter.sv
hdl/ctrl_sequencer.sv
hdl/ctrl_word_gen.sv
hdl/control_unit.sv
tests/tb_control_unit.sv

// ==== hdl/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_ctrl_consts.svh"

module control_unit (
    input  logic                     clk,
    input  logic                     reset_in,
    input  logic [5:0]               opcode,
    input  logic [15:0]              immediate,
    input  logic                     overflow,
    output cpu_ctrl_pkg::ctrl_word_t ctrl
);

    cpu_ctrl_pkg::instr_class_e instr_class;
    cpu_ctrl_pkg::instr_class_e cur_class;
    cpu_ctrl_pkg::phase_e       phase;
    cpu_ctrl_pkg::exc_cause_e   cause;
    logic [`STEP_W-1:0]         step;
    logic                       clear;
    logic                       advance;

    instr_decoder i_instr_decoder (
        .opcode      (opcode),
        .immediate   (immediate),
        .instr_class (instr_class)
    );

    step_counter i_step_counter (
        .clk      (clk),
        .reset_in (reset_in),
        .clear    (clear),
        .advance  (advance),
        .step     (step)
    );

    ctrl_sequencer i_ctrl_sequencer (
        .clk         (clk),
        .reset_in    (reset_in),
        .instr_class (instr_class),
        .overflow    (overflow),
        .step        (step),
        .phase       (phase),
        .cur_class   (cur_class),
        .cause       (cause),
        .clear       (clear),
        .advance     (advance)
    );

    ctrl_word_gen i_ctrl_word_gen (
        .clk       (clk),
        .reset_in  (reset_in),
        .phase     (phase),
        .cur_class (cur_class),
        .cause     (cause),
        .step      (step),
        .overflow  (overflow),
        .ctrl      (ctrl)
    );

endmodule

`default_nettype wire

// ==== hdl/cpu_ctrl_pkg.sv ====
`default_nettype none

package cpu_ctrl_pkg;

    typedef enum logic [1:0] {
        PHASE_FETCH     = 2'd0,
        PHASE_DECODE    = 2'd1,
        PHASE_EXECUTE   = 2'd2,
        PHASE_EXCEPTION = 2'd3
    } phase_e;

    typedef enum logic [3:0] {
        CLS_ADD     = 4'd0,
        CLS_SUB     = 4'd1,
        CLS_AND     = 4'd2,
        CLS_SLT     = 4'd3,
        CLS_ADDI    = 4'd4,
        CLS_LW      = 4'd5,
        CLS_SW      = 4'd6,
        CLS_BEQ     = 4'd7,
        CLS_BNE     = 4'd8,
        CLS_J       = 4'd9,
        CLS_ILLEGAL = 4'd10
    } instr_class_e;

    typedef enum logic {
        CAUSE_OVERFLOW = 1'b0,
        CAUSE_ILLEGAL  = 1'b1
    } exc_cause_e;

    typedef enum logic [2:0] {
        ALU_PASS = 3'b000,
        ALU_ADD  = 3'b001,
        ALU_SUB  = 3'b010,
        ALU_AND  = 3'b011,
        ALU_SLT  = 3'b110
    } alu_op_e;

    typedef struct packed {
        logic [2:0] address_sel;
        logic [1:0] alu_src1;
        logic [1:0] alu_src2;
        logic [1:0] pc_sel;
        logic [1:0] wr_reg_sel;
        logic [2:0] wd_reg_sel;
        logic [1:0] a_sel;
        logic       b_sel;
        logic       extend;
        logic       wd_memory;
    } mux_sel_t;

    typedef struct packed {
        logic address_rg;
        logic epc;
        logic mdr;
        logic ir;
        logic a;
        logic b;
        logic alu_out;
    } load_en_t;

    typedef struct packed {
        mux_sel_t sel;
        load_en_t load;
        logic     memory_wr;
        logic     reg_wr;
        logic     pc_write;
        logic     is_beq;
        logic     is_bne;
        alu_op_e  alu_op;
    } ctrl_word_t;

    // Instructions whose address or result add can overflow
    function automatic logic tests_overflow(instr_class_e c);
        return c inside {CLS_ADD, CLS_SUB, CLS_ADDI, CLS_LW, CLS_SW};
    endfunction

endpackage

`default_nettype wire

// ==== hdl/ctrl_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_ctrl_consts.svh"

module ctrl_sequencer (
    input  logic                       clk,
    input  logic                       reset_in,
    input  cpu_ctrl_pkg::instr_class_e instr_class,
    input  logic                       overflow,
    input  logic [`STEP_W-1:0]         step,
    output cpu_ctrl_pkg::phase_e       phase,
    output cpu_ctrl_pkg::instr_class_e cur_class,
    output cpu_ctrl_pkg::exc_cause_e   cause,
    output logic                       clear,
    output logic                       advance
);

    import cpu_ctrl_pkg::*;

    localparam logic [`STEP_W-1:0] FETCH_LAST  = `FETCH_STEPS - 1;
    localparam logic [`STEP_W-1:0] DECODE_LAST = `DECODE_STEPS - 1;
    localparam logic [`STEP_W-1:0] EXC_LAST    = `EXC_STEPS - 1;
    localparam logic [`STEP_W-1:0] LW_LAST     = `MEM_WAIT_LAST + 2;
    localparam logic [`STEP_W-1:0] OVF_STEP    = 1;

    phase_e             phase_next;
    exc_cause_e         cause_next;
    logic [`STEP_W-1:0] exec_last;
    logic               decode_done;

    assign decode_done = (phase == PHASE_DECODE) && (step == DECODE_LAST);

    // Length of execute depends on the latched class
    always_comb begin
        case (cur_class)
            CLS_LW:                  exec_last = LW_LAST;
            CLS_BEQ, CLS_BNE, CLS_J: exec_last = '0;
            default:                 exec_last = OVF_STEP;
        endcase
    end

    always_comb begin
        phase_next = phase;
        cause_next = cause;
        case (phase)
            PHASE_FETCH: begin
                if (step == FETCH_LAST) begin
                    phase_next = PHASE_DECODE;
                end
            end
            PHASE_DECODE: begin
                if (decode_done) begin
                    if (instr_class == CLS_ILLEGAL) begin
                        phase_next = PHASE_EXCEPTION;
                        cause_next = CAUSE_ILLEGAL;
                    end else begin
                        phase_next = PHASE_EXECUTE;
                    end
                end
            end
            PHASE_EXECUTE: begin
                if (step == OVF_STEP && tests_overflow(cur_class) && overflow) begin
                    phase_next = PHASE_EXCEPTION;
                    cause_next = CAUSE_OVERFLOW;
                end else if (step == exec_last) begin
                    phase_next = PHASE_FETCH;
                end
            end
            default: begin
                if (step == EXC_LAST) begin
                    phase_next = PHASE_FETCH;
                end
            end
        endcase
    end

    // Step restarts on every phase change
    assign clear   = (phase_next != phase);
    assign advance = !clear;

    always_ff @(posedge clk) begin
        if (reset_in) begin
            phase     <= PHASE_FETCH;
            cause     <= CAUSE_OVERFLOW;
            cur_class <= CLS_ILLEGAL;
        end else begin
            phase <= phase_next;
            cause <= cause_next;
            if (decode_done) begin
                cur_class <= instr_class;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ctrl_word_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_ctrl_consts.svh"

module ctrl_word_gen (
    input  logic                       clk,
    input  logic                       reset_in,
    input  cpu_ctrl_pkg::phase_e       phase,
    input  cpu_ctrl_pkg::instr_class_e cur_class,
    input  cpu_ctrl_pkg::exc_cause_e   cause,
    input  logic [`STEP_W-1:0]         step,
    input  logic                       overflow,
    output cpu_ctrl_pkg::ctrl_word_t   ctrl
);

    import cpu_ctrl_pkg::*;

    localparam logic [`STEP_W-1:0] FETCH_LAST = `FETCH_STEPS - 1;
    localparam logic [`STEP_W-1:0] EXC_LAST   = `EXC_STEPS - 1;
    localparam logic [`STEP_W-1:0] MEM_LAST   = `MEM_WAIT_LAST;
    localparam logic [`STEP_W-1:0] OVF_STEP   = 1;

    ctrl_word_t ctrl_next;
    alu_op_e    r_op;
    logic [2:0] vec_sel;

    // First execute cycle, A op src2 into alu_out
    function automatic ctrl_word_t alu_stage(ctrl_word_t w, logic [1:0] src2, alu_op_e op);
        ctrl_word_t r;
        r              = w;
        r.sel.alu_src1 = `SRC1_A;
        r.sel.alu_src2 = src2;
        r.sel.extend   = (src2 != `SRC2_B);
        r.alu_op       = op;
        r.load.alu_out = 1'b1;
        return r;
    endfunction

    always_comb begin
        case (cur_class)
            CLS_SUB: r_op = ALU_SUB;
            CLS_AND: r_op = ALU_AND;
            CLS_SLT: r_op = ALU_SLT;
            default: r_op = ALU_ADD;
        endcase
    end

    assign vec_sel = (cause == CAUSE_ILLEGAL) ? `ADDR_SEL_VEC_ILLEGAL : `ADDR_SEL_VEC_OVERFLOW;

    always_comb begin
        // Selects hold their last value, strobes drop
        ctrl_next           = ctrl;
        ctrl_next.load      = '0;
        ctrl_next.memory_wr = 1'b0;
        ctrl_next.reg_wr    = 1'b0;
        ctrl_next.pc_write  = 1'b0;
        ctrl_next.is_beq    = 1'b0;
        ctrl_next.is_bne    = 1'b0;

        case (phase)
            PHASE_FETCH: begin
                if (step < FETCH_LAST) begin
                    ctrl_next.sel.address_sel = `ADDR_SEL_PC;
                    ctrl_next.sel.alu_src1    = `SRC1_PC;
                    ctrl_next.sel.alu_src2    = `SRC2_FOUR;
                    ctrl_next.alu_op          = ALU_ADD;
                    ctrl_next.load.address_rg = 1'b1;
                    ctrl_next.load.alu_out    = 1'b1;
                end else begin
                    ctrl_next.sel.pc_sel = `PC_SEL_ALU_RESULT;
                    ctrl_next.load.ir    = 1'b1;
                    ctrl_next.pc_write   = 1'b1;
                end
            end
            PHASE_DECODE: begin
                if (step == '0) begin
                    // Branch target ahead of time
                    ctrl_next.sel.extend   = 1'b1;
                    ctrl_next.sel.alu_src1 = `SRC1_PC;
                    ctrl_next.sel.alu_src2 = `SRC2_IMM_SHIFTED;
                    ctrl_next.alu_op       = ALU_ADD;
                    ctrl_next.load.alu_out = 1'b1;
                end else begin
                    // A and B from the register file read ports
                    ctrl_next.sel.a_sel = 2'b01;
                    ctrl_next.sel.b_sel = 1'b0;
                    ctrl_next.load.a    = 1'b1;
                    ctrl_next.load.b    = 1'b1;
                end
            end
            PHASE_EXECUTE: begin
                if (step == OVF_STEP && tests_overflow(cur_class) && overflow) begin
                    // Overflow cycle stays quiet
                end else begin
                    case (cur_class)
                        CLS_ADD, CLS_SUB, CLS_AND, CLS_SLT: begin
                            if (step == '0) begin
                                ctrl_next = alu_stage(ctrl_next, `SRC2_B, r_op);
                            end else begin
                                ctrl_next.sel.wr_reg_sel = `WR_SEL_RD;
                                ctrl_next.sel.wd_reg_sel = `WD_SEL_ALU_OUT;
                                ctrl_next.reg_wr         = 1'b1;
                            end
                        end
                        CLS_ADDI: begin
                            if (step == '0) begin
                                ctrl_next = alu_stage(ctrl_next, `SRC2_IMM, ALU_ADD);
                            end else begin
                                ctrl_next.sel.wr_reg_sel = `WR_SEL_RT;
                                ctrl_next.sel.wd_reg_sel = `WD_SEL_ALU_OUT;
                                ctrl_next.reg_wr         = 1'b1;
                            end
                        end
                        CLS_LW: begin
                            if (step == '0) begin
                                ctrl_next = alu_stage(ctrl_next, `SRC2_IMM, ALU_ADD);
                            end else if (step <= MEM_LAST) begin
                                ctrl_next.sel.address_sel = `ADDR_SEL_ALU_OUT;
                            end else if (step == MEM_LAST + 1'b1) begin
                                ctrl_next.sel.address_sel = `ADDR_SEL_ALU_OUT;
                                ctrl_next.load.mdr        = 1'b1;
                            end else begin
                                ctrl_next.sel.wr_reg_sel = `WR_SEL_RT;
                                ctrl_next.sel.wd_reg_sel = `WD_SEL_MDR;
                                ctrl_next.reg_wr         = 1'b1;
                            end
                        end
                        CLS_SW: begin
                            if (step == '0) begin
                                ctrl_next = alu_stage(ctrl_next, `SRC2_IMM, ALU_ADD);
                            end else begin
                                ctrl_next.sel.address_sel = `ADDR_SEL_ALU_OUT;
                                ctrl_next.sel.wd_memory   = 1'b0;
                                ctrl_next.memory_wr       = 1'b1;
                            end
                        end
                        CLS_BEQ, CLS_BNE: begin
                            // Compare A and B, target already in alu_out
                            ctrl_next.sel.alu_src1 = `SRC1_A;
                            ctrl_next.sel.alu_src2 = `SRC2_B;
                            ctrl_next.sel.pc_sel   = `PC_SEL_ALU_OUT;
                            ctrl_next.alu_op       = ALU_SUB;
                            ctrl_next.is_beq       = (cur_class == CLS_BEQ);
                            ctrl_next.is_bne       = (cur_class == CLS_BNE);
                        end
                        CLS_J: begin
                            ctrl_next.sel.pc_sel = `PC_SEL_JUMP;
                            ctrl_next.pc_write   = 1'b1;
                        end
                        default: begin
                        end
                    endcase
                end
            end
            default: begin
                if (step < EXC_LAST) begin
                    ctrl_next.sel.address_sel = vec_sel;
                    if (step == EXC_LAST - 1'b1) begin
                        ctrl_next.load.epc = 1'b1;
                        ctrl_next.load.mdr = 1'b1;
                    end
                end else begin
                    ctrl_next.sel.extend = 1'b0;
                    ctrl_next.sel.pc_sel = `PC_SEL_ALU_OUT;
                    ctrl_next.pc_write   = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_in) begin
            ctrl <= '0;
        end else begin
            ctrl <= ctrl_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_ctrl_consts.svh"

module instr_decoder (
    input  logic [5:0]                 opcode,
    input  logic [15:0]                immediate,
    output cpu_ctrl_pkg::instr_class_e instr_class
);

    import cpu_ctrl_pkg::*;

    logic [5:0] funct;

    // funct sits in the low bits of the immediate field
    assign funct = immediate[5:0];

    always_comb begin
        case (opcode)
            `OP_R: begin
                case (funct)
                    `FUNCT_ADD: instr_class = CLS_ADD;
                    `FUNCT_SUB: instr_class = CLS_SUB;
                    `FUNCT_AND: instr_class = CLS_AND;
                    `FUNCT_SLT: instr_class = CLS_SLT;
                    default:    instr_class = CLS_ILLEGAL;
                endcase
            end
            `OP_ADDI: instr_class = CLS_ADDI;
            `OP_LW:   instr_class = CLS_LW;
            `OP_SW:   instr_class = CLS_SW;
            `OP_BEQ:  instr_class = CLS_BEQ;
            `OP_BNE:  instr_class = CLS_BNE;
            `OP_J:    instr_class = CLS_J;
            default:  instr_class = CLS_ILLEGAL;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/step_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_ctrl_consts.svh"

module step_counter (
    input  logic               clk,
    input  logic               reset_in,
    input  logic               clear,
    input  logic               advance,
    output logic [`STEP_W-1:0] step
);

    localparam logic [`STEP_W-1:0] STEP_MAX = {`STEP_W{1'b1}};

    always_ff @(posedge clk) begin
        if (reset_in) begin
            step <= '0;
        end else if (clear) begin
            step <= '0;
        end else if (advance && step != STEP_MAX) begin
            // Holds at the top instead of wrapping
            step <= step + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== include/cpu_ctrl_consts.svh ====
`ifndef CPU_CTRL_CONSTS_SVH
`define CPU_CTRL_CONSTS_SVH

// Opcodes
`define OP_R                    6'b000000
`define OP_ADDI                 6'b001000
`define OP_LW                   6'b100011
`define OP_SW                   6'b101011
`define OP_BEQ                  6'b000100
`define OP_BNE                  6'b000101
`define OP_J                    6'b000010

// R-type funct field
`define FUNCT_ADD               6'b100000
`define FUNCT_SUB               6'b100010
`define FUNCT_AND               6'b100100
`define FUNCT_SLT               6'b101010

// Memory address mux
`define ADDR_SEL_PC             3'b000
`define ADDR_SEL_ALU_OUT        3'b001
`define ADDR_SEL_VEC_ILLEGAL    3'b010
`define ADDR_SEL_VEC_OVERFLOW   3'b011

// PC source mux
`define PC_SEL_ALU_OUT          2'b01
`define PC_SEL_ALU_RESULT       2'b10
`define PC_SEL_JUMP             2'b11

// Register file write port
`define WR_SEL_RT               2'b00
`define WR_SEL_RD               2'b11
`define WD_SEL_ALU_OUT          3'b010
`define WD_SEL_MDR              3'b011

// ALU operands
`define SRC1_PC                 2'b00
`define SRC1_A                  2'b01
`define SRC2_B                  2'b00
`define SRC2_FOUR               2'b01
`define SRC2_IMM                2'b10
`define SRC2_IMM_SHIFTED        2'b11

// Cycles per phase
`define FETCH_STEPS             4
`define DECODE_STEPS            2
`define MEM_WAIT_LAST           3
`define EXC_STEPS               5
`define STEP_W                  3

`endif

// ==== tests/tb_control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_ctrl_consts.svh"

module tb_control_unit;

    import cpu_ctrl_pkg::*;

    localparam int TIMEOUT_CYCLES = 40;
    localparam int NUM_RANDOM     = 300;
    localparam int NUM_KINDS      = 12;

    // Instruction kinds of the stimulus
    localparam int K_ADD       = 0;
    localparam int K_SUB       = 1;
    localparam int K_AND       = 2;
    localparam int K_SLT       = 3;
    localparam int K_ADDI      = 4;
    localparam int K_LW        = 5;
    localparam int K_SW        = 6;
    localparam int K_BEQ       = 7;
    localparam int K_BNE       = 8;
    localparam int K_J         = 9;
    localparam int K_BAD_OP    = 10;
    localparam int K_BAD_FUNCT = 11;

    logic        clk;
    logic        reset_in;
    logic [5:0]  opcode;
    logic [15:0] immediate;
    logic        overflow;
    ctrl_word_t  ctrl;
    integer      seed;
    ctrl_word_t  trace[$];

    control_unit i_control_unit (
        .clk       (clk),
        .reset_in  (reset_in),
        .opcode    (opcode),
        .immediate (immediate),
        .overflow  (overflow),
        .ctrl      (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic report_error(input string msg);
        $display("[ERROR] t=%0t %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "stopping on first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display(">>> FAIL");
        $fatal(1, "stopping on timeout");
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        assert (got == exp)
            else report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
    endtask

    function automatic logic write_strobes_idle(ctrl_word_t w);
        return !w.memory_wr && !w.reg_wr && !w.pc_write && !w.is_beq && !w.is_bne;
    endfunction

    function automatic logic strobes_quiet(ctrl_word_t w);
        return w.load == '0 && write_strobes_idle(w);
    endfunction

    function automatic logic known_opcode(logic [5:0] op);
        return op inside {`OP_R, `OP_ADDI, `OP_LW, `OP_SW, `OP_BEQ, `OP_BNE, `OP_J};
    endfunction

    function automatic logic known_funct(logic [5:0] f);
        return f inside {`FUNCT_ADD, `FUNCT_SUB, `FUNCT_AND, `FUNCT_SLT};
    endfunction

    // ALU operation implied by the R-type funct
    function automatic alu_op_e expected_alu_op(logic [5:0] funct);
        case (funct)
            `FUNCT_ADD: return ALU_ADD;
            `FUNCT_SUB: return ALU_SUB;
            `FUNCT_AND: return ALU_AND;
            `FUNCT_SLT: return ALU_SLT;
            default:    return ALU_PASS;
        endcase
    endfunction

    task automatic encode_instr(input int kind, output logic [5:0] op, output logic [15:0] imm);
        imm = 16'($random(seed));
        op  = `OP_R;
        case (kind)
            K_ADD:  imm[5:0] = `FUNCT_ADD;
            K_SUB:  imm[5:0] = `FUNCT_SUB;
            K_AND:  imm[5:0] = `FUNCT_AND;
            K_SLT:  imm[5:0] = `FUNCT_SLT;
            K_ADDI: op = `OP_ADDI;
            K_LW:   op = `OP_LW;
            K_SW:   op = `OP_SW;
            K_BEQ:  op = `OP_BEQ;
            K_BNE:  op = `OP_BNE;
            K_J:    op = `OP_J;
            K_BAD_OP: begin
                op = 6'($random(seed));
                if (known_opcode(op)) begin
                    op = 6'b111111;
                end
            end
            K_BAD_FUNCT: begin
                // Random funct outside the supported four
                if (known_funct(imm[5:0])) begin
                    imm[5:0] = 6'b000000;
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_reset_and_first_fetch();
        load_en_t fetch_load;
        logic     found;
        int       n_fetch;
        int       i;

        fetch_load            = '0;
        fetch_load.address_rg = 1'b1;
        fetch_load.alu_out    = 1'b1;
        for (i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i == 4) begin
                reset_in <= 1'b0;
            end
            @(negedge clk);
            assert (ctrl == '0) else report_error("control word not cleared in reset");
        end
        found   = 1'b0;
        n_fetch = 0;
        while (!found && n_fetch < TIMEOUT_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            found = ctrl.load.ir;
            if (!found) begin
                assert (ctrl.load == fetch_load && write_strobes_idle(ctrl)
                        && ctrl.sel.address_sel == `ADDR_SEL_PC)
                    else report_error("bad control word in first fetch");
                n_fetch++;
            end
        end
        if (!found) begin
            report_timeout("the first instruction load");
        end
        check_count("fetch cycles before first ir_load", n_fetch, `FETCH_STEPS - 1);
    endtask

    task automatic run_instr(input int kind, input logic ovf);
        logic [5:0]  op;
        logic [15:0] imm;
        ctrl_word_t  w;
        logic        found;
        logic        is_r;
        logic        writes;
        logic        illegal;
        logic        exc_ovf;
        logic        exc;
        logic [2:0]  exp_vec;
        int          period;
        int          exp_period;
        int          n_reg_wr;
        int          n_mem_wr;
        int          n_beq;
        int          n_bne;
        int          n_pc_wr;
        int          n_epc;
        int          n_mdr;
        int          n_vec;

        encode_instr(kind, op, imm);
        is_r    = kind <= K_SLT;
        writes  = is_r || kind == K_ADDI || kind == K_LW;
        illegal = kind == K_BAD_OP || kind == K_BAD_FUNCT;
        exc_ovf = ovf && (kind inside {K_ADD, K_SUB, K_ADDI, K_LW, K_SW});
        exc     = illegal || exc_ovf;
        exp_vec = illegal ? `ADDR_SEL_VEC_ILLEGAL : `ADDR_SEL_VEC_OVERFLOW;
        if (illegal) begin
            exp_period = 11;
        end else if (exc_ovf) begin
            exp_period = 13;
        end else if (kind == K_LW) begin
            exp_period = 12;
        end else if (kind inside {K_BEQ, K_BNE, K_J}) begin
            exp_period = 7;
        end else begin
            exp_period = 8;
        end

        // New instruction one cycle after ir_load
        @(posedge clk);
        opcode    <= op;
        immediate <= imm;
        overflow  <= ovf;
        trace.delete();
        found  = 1'b0;
        period = 0;
        while (!found && period < TIMEOUT_CYCLES) begin
            @(negedge clk);
            trace.push_back(ctrl);
            period++;
            found = ctrl.load.ir;
            if (!found) begin
                @(posedge clk);
            end
        end
        if (!found) begin
            report_timeout($sformatf("the ir_load after opcode %b", op));
        end
        assert (period == exp_period)
            else report_error($sformatf("kind %0d ovf %0b: period %0d, expected %0d",
                                        kind, ovf, period, exp_period));

        n_reg_wr = 0;
        n_mem_wr = 0;
        n_beq    = 0;
        n_bne    = 0;
        n_pc_wr  = 0;
        n_epc    = 0;
        n_mdr    = 0;
        n_vec    = 0;
        foreach (trace[i]) begin
            w = trace[i];
            if (w.reg_wr) begin
                assert (w.sel.wr_reg_sel == (is_r ? `WR_SEL_RD : `WR_SEL_RT)
                        && w.sel.wd_reg_sel == (kind == K_LW ? `WD_SEL_MDR : `WD_SEL_ALU_OUT)
                        && (kind != K_LW || n_mdr == 1))
                    else report_error($sformatf("kind %0d: bad reg_wr selects", kind));
            end
            if (w.memory_wr) begin
                assert (w.sel.address_sel == `ADDR_SEL_ALU_OUT)
                    else report_error("memory_wr without ALU address");
            end
            if (w.load.epc) begin
                assert (w.load.mdr && w.sel.address_sel == exp_vec && n_vec == 3)
                    else report_error($sformatf("kind %0d: bad exception vector", kind));
            end
            if (w.pc_write && i < period - 1) begin
                if (exc) begin
                    assert (w.sel.pc_sel == `PC_SEL_ALU_OUT && n_epc == 1)
                        else report_error("bad pc_write in exception");
                end else begin
                    assert (w.sel.pc_sel == `PC_SEL_JUMP)
                        else report_error("bad pc_write for jump");
                end
            end
            if (w.sel.address_sel == exp_vec && n_epc == 0) begin
                n_vec++;
            end
            n_reg_wr += w.reg_wr;
            n_mem_wr += w.memory_wr;
            n_beq    += w.is_beq;
            n_bne    += w.is_bne;
            n_pc_wr  += w.pc_write;
            n_epc    += w.load.epc;
            n_mdr    += w.load.mdr;
        end

        assert (trace[period-1].pc_write && trace[period-1].sel.pc_sel == `PC_SEL_ALU_RESULT)
            else report_error("ir_load without PC update");
        if (is_r) begin
            assert (trace[2].load.alu_out && trace[2].alu_op == expected_alu_op(imm[5:0]))
                else report_error($sformatf("kind %0d: alu_op %b", kind, trace[2].alu_op));
        end
        if (exc_ovf) begin
            assert (strobes_quiet(trace[3]))
                else report_error("strobes active in overflow cycle");
        end
        check_count("reg_wr pulses", n_reg_wr, (writes && !exc) ? 1 : 0);
        check_count("memory_wr pulses", n_mem_wr, (kind == K_SW && !exc) ? 1 : 0);
        check_count("is_beq pulses", n_beq, (kind == K_BEQ) ? 1 : 0);
        check_count("is_bne pulses", n_bne, (kind == K_BNE) ? 1 : 0);
        check_count("pc_write pulses", n_pc_wr, 1 + (kind == K_J ? 1 : 0) + (exc ? 1 : 0));
        check_count("epc_load pulses", n_epc, exc ? 1 : 0);
        check_count("mdr_load pulses", n_mdr,
                    (exc ? 1 : 0) + ((kind == K_LW && !exc) ? 1 : 0));
    endtask

    initial begin
        int   k;
        int   kind;
        logic ovf;

        seed      = 53081;
        reset_in  = 1'b1;
        opcode    = 6'd0;
        immediate = 16'd0;
        overflow  = 1'b0;

        check_reset_and_first_fetch();

        // Every kind once without and once with overflow
        for (k = 0; k < NUM_KINDS; k++) begin
            run_instr(k, 1'b0);
        end
        for (k = 0; k < NUM_KINDS; k++) begin
            run_instr(k, 1'b1);
        end

        for (k = 0; k < NUM_RANDOM; k++) begin
            kind = int'($unsigned($random(seed)) % NUM_KINDS);
            ovf  = ($random(seed) & 3) == 0;
            run_instr(kind, ovf);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire
